/* design/wg_alloc_params.svh */
`ifndef WG_ALLOC_PARAMS_SVH
`define WG_ALLOC_PARAMS_SVH

//////////////////////////////
// Compute unit array
//////////////////////////////

`define WA_NUM_CU      8
`define WA_CU_ID_W     3

// Workgroup tag carried through the pipe
`define WA_WG_ID_W     6

//////////////////////////////
// Resource address widths
//////////////////////////////

// Amounts are one bit wider so a fully free CU can be expressed
`define WA_VGPR_W      6
`define WA_LDS_W       6

// Free wavefront slots per CU
`define WA_WF_SLOT_W   4

// Wavefronts asked for by one workgroup
`define WA_WF_CNT_W    3

`endif

/* design/wg_alloc_pkg.sv */
`include "wg_alloc_params.svh"

package wg_alloc_pkg;

   //////////////////////////////
   // CU addressing
   //////////////////////////////

   typedef logic [`WA_CU_ID_W-1:0] cu_id_t;
   typedef logic [`WA_NUM_CU-1:0]  cu_mask_t;

   typedef logic [`WA_WG_ID_W-1:0] wg_id_t;

   //////////////////////////////
   // Resource fields
   //////////////////////////////

   // Start addresses
   typedef logic [`WA_VGPR_W-1:0]  vgpr_addr_t;
   typedef logic [`WA_LDS_W-1:0]   lds_addr_t;

   // Amounts, full range included
   typedef logic [`WA_VGPR_W:0]    vgpr_size_t;
   typedef logic [`WA_LDS_W:0]     lds_size_t;

   // Wavefront slots and counts
   typedef logic [`WA_WF_SLOT_W:0] wf_slots_t;
   typedef logic [`WA_WF_CNT_W-1:0] wf_cnt_t;

endpackage

/* design/wg_alloc_ifs.sv */
// Staged table write shared by the three CAMs and the start RAM
interface cam_update_if import wg_alloc_pkg::*; ();

   logic       upd_valid;
   cu_id_t     upd_cu_id;
   vgpr_addr_t upd_vgpr_start;
   vgpr_size_t upd_vgpr_free;
   lds_addr_t  upd_lds_start;
   lds_size_t  upd_lds_free;
   wf_slots_t  upd_wf_free;

   modport source (
      output upd_valid, upd_cu_id,
      output upd_vgpr_start, upd_vgpr_free,
      output upd_lds_start, upd_lds_free,
      output upd_wf_free
   );

   modport sink (
      input upd_valid, upd_cu_id,
      input upd_vgpr_start, upd_vgpr_free,
      input upd_lds_start, upd_lds_free,
      input upd_wf_free
   );

endinterface

// Search request and pipeline advance
interface cam_search_if import wg_alloc_pkg::*; ();

   logic       search_en;
   vgpr_size_t vgpr_need;
   lds_size_t  lds_need;
   wf_cnt_t    wf_need;
   logic       advance;

   modport requester (
      output search_en, vgpr_need, lds_need, wf_need, advance
   );

   modport searcher (
      input search_en, vgpr_need, lds_need, wf_need, advance
   );

endinterface

/* design/alloc_cam.sv */
`include "wg_alloc_params.svh"

// RES_SEL 0 picks VGPR, 1 LDS and 2 the wavefront slots
module alloc_cam import wg_alloc_pkg::*; #(
   parameter int RES_W   = 7,
   parameter int RES_SEL = 0
) (
   input  logic           clk,
   input  logic           rst,
   cam_update_if.sink     upd,
   cam_search_if.searcher srch,
   output cu_mask_t       match_o
);

   logic [RES_W-1:0] free_q [`WA_NUM_CU];
   logic [RES_W-1:0] wr_amount;
   logic [RES_W-1:0] need;
   cu_mask_t         hit;

   generate
      if (RES_SEL == 0) begin : g_vgpr
         assign wr_amount = RES_W'(upd.upd_vgpr_free);
         assign need      = RES_W'(srch.vgpr_need);
      end else if (RES_SEL == 1) begin : g_lds
         assign wr_amount = RES_W'(upd.upd_lds_free);
         assign need      = RES_W'(srch.lds_need);
      end else begin : g_wf
         assign wr_amount = RES_W'(upd.upd_wf_free);
         // Zero-extend the request count to the slot width
         assign need      = {{(RES_W-`WA_WF_CNT_W){1'b0}}, srch.wf_need};
      end
   endgenerate

   // Parallel compare across all CUs
   always_comb begin
      for (int i = 0; i < `WA_NUM_CU; i++) begin
         hit[i] = (free_q[i] >= need);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `WA_NUM_CU; i++) begin
            free_q[i] <= '0;
         end
         match_o <= '0;
      end else begin
         if (upd.upd_valid) begin
            free_q[upd.upd_cu_id] <= wr_amount;
         end
         if (srch.search_en && srch.advance) begin
            match_o <= hit;
         end
      end
   end

endmodule

/* design/start_ram.sv */
`include "wg_alloc_params.svh"

module start_ram import wg_alloc_pkg::*; (
   input  logic              clk,
   input  logic              rst,
   cam_update_if.sink        upd,
   input  logic              rd_en_i,
   input  cu_id_t            rd_addr_i,
   output vgpr_addr_t        vgpr_start_o,
   output lds_addr_t         lds_start_o
);

   vgpr_addr_t vgpr_mem [`WA_NUM_CU];
   lds_addr_t  lds_mem  [`WA_NUM_CU];

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Never-written CUs read back start zero
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `WA_NUM_CU; i++) begin
            vgpr_mem[i] <= '0;
            lds_mem[i]  <= '0;
         end
      end else if (upd.upd_valid) begin
         vgpr_mem[upd.upd_cu_id] <= upd.upd_vgpr_start;
         lds_mem[upd.upd_cu_id]  <= upd.upd_lds_start;
      end
   end

   //////////////////////////////
   // Registered read
   //////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         vgpr_start_o <= '0;
         lds_start_o  <= '0;
      end else if (rd_en_i) begin
         vgpr_start_o <= vgpr_mem[rd_addr_i];
         lds_start_o  <= lds_mem[rd_addr_i];
      end
   end

endmodule

/* design/cu_select.sv */
`include "wg_alloc_params.svh"

module cu_select import wg_alloc_pkg::*; (
   input  logic           clk,
   input  logic           rst,
   cam_search_if.searcher srch,
   input  cu_mask_t       vgpr_match_i,
   input  cu_mask_t       lds_match_i,
   input  cu_mask_t       wf_match_i,
   input  cu_mask_t       busy_i,
   output logic           cand_found_o,
   output cu_id_t         cand_cu_id_o
);

   cu_mask_t anded_q;
   logic     found_d;
   cu_id_t   cu_id_d;

   //////////////////////////////
   // Candidate mask
   //////////////////////////////

   // A CU qualifies only if all three fit and it is idle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         anded_q <= '0;
      end else if (srch.advance) begin
         anded_q <= vgpr_match_i & lds_match_i & wf_match_i & ~busy_i;
      end
   end

   //////////////////////////////
   // Priority encoder
   //////////////////////////////

   // Scan downwards so the lowest set index is the last one kept
   always_comb begin
      found_d = 1'b0;
      cu_id_d = '0;
      for (int i = `WA_NUM_CU - 1; i >= 0; i--) begin
         if (anded_q[i]) begin
            found_d = 1'b1;
            cu_id_d = cu_id_t'(i);
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cand_found_o <= 1'b0;
         cand_cu_id_o <= '0;
      end else if (srch.advance) begin
         cand_found_o <= found_d;
         cand_cu_id_o <= cu_id_d;
      end
   end

endmodule

/* design/alloc_pipe_ctrl.sv */
module alloc_pipe_ctrl import wg_alloc_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   // Request side
   input  logic             start_alloc_i,
   input  wg_id_t           req_wg_id_i,
   input  vgpr_size_t       req_vgpr_size_i,
   input  lds_size_t        req_lds_size_i,
   input  wf_cnt_t          req_num_wf_i,
   input  cu_mask_t         cu_busy_i,
   input  logic             alloc_ack_i,
   // Table update side
   input  logic             upd_valid_i,
   input  cu_id_t           upd_cu_id_i,
   input  vgpr_addr_t       upd_vgpr_start_i,
   input  vgpr_size_t       upd_vgpr_free_i,
   input  lds_addr_t        upd_lds_start_i,
   input  lds_size_t        upd_lds_free_i,
   input  wf_slots_t        upd_wf_free_i,
   cam_update_if.source     upd,
   cam_search_if.requester  srch,
   output cu_mask_t         busy_o,
   input  logic             cand_found_i,
   input  cu_id_t           cand_cu_id_i,
   output logic             ram_rd_en_o,
   output cu_id_t           ram_rd_addr_o,
   // Result
   output logic             alloc_valid_o,
   output logic             alloc_rejected_o,
   output wg_id_t           alloc_wg_id_o,
   output cu_id_t           alloc_cu_id_o,
   output wf_cnt_t          alloc_wf_count_o
);

   logic       freeze_q;
   logic       advance;

   logic       s1_valid, s2_valid, s3_valid, s4_valid;
   wg_id_t     s1_wg_id, s2_wg_id, s3_wg_id, s4_wg_id;
   wf_cnt_t    s1_wf_cnt, s2_wf_cnt, s3_wf_cnt, s4_wf_cnt;
   vgpr_size_t s1_vgpr;
   lds_size_t  s1_lds;
   cu_mask_t   s1_busy, s2_busy;

   assign advance = ~freeze_q;

   assign srch.advance   = advance;
   assign srch.search_en = s1_valid;
   assign srch.vgpr_need = s1_vgpr;
   assign srch.lds_need  = s1_lds;
   assign srch.wf_need   = s1_wf_cnt;

   // Busy lines up with the registered match vectors
   assign busy_o = s2_busy;

   assign ram_rd_en_o   = advance & s4_valid & cand_found_i;
   assign ram_rd_addr_o = cand_cu_id_i;

   //////////////////////////////
   // Request pipeline
   //////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         s1_valid  <= 1'b0;
         s2_valid  <= 1'b0;
         s3_valid  <= 1'b0;
         s4_valid  <= 1'b0;
         s1_wg_id  <= '0;
         s2_wg_id  <= '0;
         s3_wg_id  <= '0;
         s4_wg_id  <= '0;
         s1_wf_cnt <= '0;
         s2_wf_cnt <= '0;
         s3_wf_cnt <= '0;
         s4_wf_cnt <= '0;
         s1_vgpr   <= '0;
         s1_lds    <= '0;
         s1_busy   <= '0;
         s2_busy   <= '0;
      end else if (advance) begin
         s1_valid  <= start_alloc_i;
         s1_wg_id  <= req_wg_id_i;
         s1_wf_cnt <= req_num_wf_i;
         s1_vgpr   <= req_vgpr_size_i;
         s1_lds    <= req_lds_size_i;
         s1_busy   <= cu_busy_i;
         s2_valid  <= s1_valid;
         s2_wg_id  <= s1_wg_id;
         s2_wf_cnt <= s1_wf_cnt;
         s2_busy   <= s1_busy;
         s3_valid  <= s2_valid;
         s3_wg_id  <= s2_wg_id;
         s3_wf_cnt <= s2_wf_cnt;
         s4_valid  <= s3_valid;
         s4_wg_id  <= s3_wg_id;
         s4_wf_cnt <= s3_wf_cnt;
      end
   end

   //////////////////////////////
   // Freeze and result register
   //////////////////////////////

   // Result is held until the controller acks it
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         freeze_q         <= 1'b0;
         alloc_valid_o    <= 1'b0;
         alloc_rejected_o <= 1'b0;
         alloc_wg_id_o    <= '0;
         alloc_cu_id_o    <= '0;
         alloc_wf_count_o <= '0;
      end else if (freeze_q) begin
         if (alloc_ack_i) begin
            freeze_q <= 1'b0;
         end
      end else begin
         freeze_q         <= s4_valid;
         alloc_valid_o    <= s4_valid;
         alloc_rejected_o <= s4_valid & ~cand_found_i;
         alloc_wg_id_o    <= s4_wg_id;
         alloc_cu_id_o    <= cand_cu_id_i;
         alloc_wf_count_o <= s4_wf_cnt;
      end
   end

   // Update staging keeps running while frozen
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         upd.upd_valid      <= 1'b0;
         upd.upd_cu_id      <= '0;
         upd.upd_vgpr_start <= '0;
         upd.upd_vgpr_free  <= '0;
         upd.upd_lds_start  <= '0;
         upd.upd_lds_free   <= '0;
         upd.upd_wf_free    <= '0;
      end else begin
         upd.upd_valid      <= upd_valid_i;
         upd.upd_cu_id      <= upd_cu_id_i;
         upd.upd_vgpr_start <= upd_vgpr_start_i;
         upd.upd_vgpr_free  <= upd_vgpr_free_i;
         upd.upd_lds_start  <= upd_lds_start_i;
         upd.upd_lds_free   <= upd_lds_free_i;
         upd.upd_wf_free    <= upd_wf_free_i;
      end
   end

endmodule

/* design/wg_alloc_top.sv */
`include "wg_alloc_params.svh"

module wg_alloc_top import wg_alloc_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   // Workgroup request
   input  logic       start_alloc_i,
   input  wg_id_t     req_wg_id_i,
   input  vgpr_size_t req_vgpr_size_i,
   input  lds_size_t  req_lds_size_i,
   input  wf_cnt_t    req_num_wf_i,
   input  cu_mask_t   cu_busy_i,
   input  logic       alloc_ack_i,
   // Resource table update
   input  logic       upd_valid_i,
   input  cu_id_t     upd_cu_id_i,
   input  vgpr_addr_t upd_vgpr_start_i,
   input  vgpr_size_t upd_vgpr_free_i,
   input  lds_addr_t  upd_lds_start_i,
   input  lds_size_t  upd_lds_free_i,
   input  wf_slots_t  upd_wf_free_i,
   // Allocation result
   output logic       alloc_valid_o,
   output logic       alloc_rejected_o,
   output wg_id_t     alloc_wg_id_o,
   output cu_id_t     alloc_cu_id_o,
   output wf_cnt_t    alloc_wf_count_o,
   output vgpr_addr_t alloc_vgpr_start_o,
   output lds_addr_t  alloc_lds_start_o
);

   cu_mask_t vgpr_match;
   cu_mask_t lds_match;
   cu_mask_t wf_match;
   cu_mask_t busy_d;
   logic     cand_found;
   cu_id_t   cand_cu_id;
   logic     ram_rd_en;
   cu_id_t   ram_rd_addr;

   cam_update_if upd_if ();
   cam_search_if srch_if ();

   alloc_pipe_ctrl u_pipe_ctrl (
      .clk              (clk),
      .rst              (rst),
      .start_alloc_i    (start_alloc_i),
      .req_wg_id_i      (req_wg_id_i),
      .req_vgpr_size_i  (req_vgpr_size_i),
      .req_lds_size_i   (req_lds_size_i),
      .req_num_wf_i     (req_num_wf_i),
      .cu_busy_i        (cu_busy_i),
      .alloc_ack_i      (alloc_ack_i),
      .upd_valid_i      (upd_valid_i),
      .upd_cu_id_i      (upd_cu_id_i),
      .upd_vgpr_start_i (upd_vgpr_start_i),
      .upd_vgpr_free_i  (upd_vgpr_free_i),
      .upd_lds_start_i  (upd_lds_start_i),
      .upd_lds_free_i   (upd_lds_free_i),
      .upd_wf_free_i    (upd_wf_free_i),
      .upd              (upd_if.source),
      .srch             (srch_if.requester),
      .busy_o           (busy_d),
      .cand_found_i     (cand_found),
      .cand_cu_id_i     (cand_cu_id),
      .ram_rd_en_o      (ram_rd_en),
      .ram_rd_addr_o    (ram_rd_addr),
      .alloc_valid_o    (alloc_valid_o),
      .alloc_rejected_o (alloc_rejected_o),
      .alloc_wg_id_o    (alloc_wg_id_o),
      .alloc_cu_id_o    (alloc_cu_id_o),
      .alloc_wf_count_o (alloc_wf_count_o)
   );

   //////////////////////////////
   // Free-resource tables
   //////////////////////////////

   alloc_cam #(.RES_W(`WA_VGPR_W + 1), .RES_SEL(0)) vgpr_cam (
      .clk(clk), .rst(rst), .upd(upd_if.sink), .srch(srch_if.searcher), .match_o(vgpr_match)
   );

   alloc_cam #(.RES_W(`WA_LDS_W + 1), .RES_SEL(1)) lds_cam (
      .clk(clk), .rst(rst), .upd(upd_if.sink), .srch(srch_if.searcher), .match_o(lds_match)
   );

   alloc_cam #(.RES_W(`WA_WF_SLOT_W + 1), .RES_SEL(2)) wf_cam (
      .clk(clk), .rst(rst), .upd(upd_if.sink), .srch(srch_if.searcher), .match_o(wf_match)
   );

   cu_select u_cu_select (
      .clk          (clk),
      .rst          (rst),
      .srch         (srch_if.searcher),
      .vgpr_match_i (vgpr_match),
      .lds_match_i  (lds_match),
      .wf_match_i   (wf_match),
      .busy_i       (busy_d),
      .cand_found_o (cand_found),
      .cand_cu_id_o (cand_cu_id)
   );

   // Start addresses for the chosen CU
   start_ram u_start_ram (
      .clk          (clk),
      .rst          (rst),
      .upd          (upd_if.sink),
      .rd_en_i      (ram_rd_en),
      .rd_addr_i    (ram_rd_addr),
      .vgpr_start_o (alloc_vgpr_start_o),
      .lds_start_o  (alloc_lds_start_o)
   );

endmodule

/* verification/wg_alloc_checker.sv */
`include "wg_alloc_params.svh"

module wg_alloc_checker import wg_alloc_pkg::*; (
   input logic       clk,
   input logic       rst,
   input logic       start_alloc_i,
   input wg_id_t     req_wg_id_i,
   input vgpr_size_t req_vgpr_size_i,
   input lds_size_t  req_lds_size_i,
   input wf_cnt_t    req_num_wf_i,
   input cu_mask_t   cu_busy_i,
   input logic       alloc_ack_i,
   input logic       upd_valid_i,
   input cu_id_t     upd_cu_id_i,
   input vgpr_addr_t upd_vgpr_start_i,
   input vgpr_size_t upd_vgpr_free_i,
   input lds_addr_t  upd_lds_start_i,
   input lds_size_t  upd_lds_free_i,
   input wf_slots_t  upd_wf_free_i,
   input logic       res_valid_i,
   input logic       res_rejected_i,
   input wg_id_t     res_wg_id_i,
   input cu_id_t     res_cu_id_i,
   input wf_cnt_t    res_wf_count_i,
   input vgpr_addr_t res_vgpr_start_i,
   input lds_addr_t  res_lds_start_i
);

   int         err_cnt = 0;

   vgpr_size_t vgpr_free_sh  [`WA_NUM_CU];
   lds_size_t  lds_free_sh   [`WA_NUM_CU];
   wf_slots_t  wf_free_sh    [`WA_NUM_CU];
   vgpr_addr_t vgpr_start_sh [`WA_NUM_CU];
   lds_addr_t  lds_start_sh  [`WA_NUM_CU];

   logic       seen_req;
   logic       exp_found;
   cu_id_t     exp_cu;
   wg_id_t     exp_wg_id;
   wf_cnt_t    exp_wf_cnt;

   // Found flag in the top bit with the CU index below it
   function automatic logic [`WA_CU_ID_W:0] lowest_fit();
      for (int i = 0; i < `WA_NUM_CU; i++) begin
         if (!cu_busy_i[i] && vgpr_free_sh[i] >= req_vgpr_size_i &&
             lds_free_sh[i] >= req_lds_size_i && wf_free_sh[i] >= req_num_wf_i) begin
            return {1'b1, cu_id_t'(i)};
         end
      end
      return '0;
   endfunction

   //////////////////////////////
   // Shadow tables
   //////////////////////////////

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < `WA_NUM_CU; i++) begin
            vgpr_free_sh[i]  <= '0;
            lds_free_sh[i]   <= '0;
            wf_free_sh[i]    <= '0;
            vgpr_start_sh[i] <= '0;
            lds_start_sh[i]  <= '0;
         end
         seen_req   <= 1'b0;
         exp_found  <= 1'b0;
         exp_cu     <= '0;
         exp_wg_id  <= '0;
         exp_wf_cnt <= '0;
      end else begin
         if (upd_valid_i) begin
            vgpr_free_sh[upd_cu_id_i]  <= upd_vgpr_free_i;
            lds_free_sh[upd_cu_id_i]   <= upd_lds_free_i;
            wf_free_sh[upd_cu_id_i]    <= upd_wf_free_i;
            vgpr_start_sh[upd_cu_id_i] <= upd_vgpr_start_i;
            lds_start_sh[upd_cu_id_i]  <= upd_lds_start_i;
         end
         if (start_alloc_i) begin
            seen_req              <= 1'b1;
            {exp_found, exp_cu}   <= lowest_fit();
            exp_wg_id             <= req_wg_id_i;
            exp_wf_cnt            <= req_num_wf_i;
         end
      end
   end

   //////////////////////////////
   // Assertions
   //////////////////////////////

   a_idle_after_reset: assert property (@(posedge clk) disable iff (rst)
      !seen_req |-> !res_valid_i)
      else begin
         $error("alloc_valid_o went high before any request was made");
         err_cnt++;
      end

   a_rejected: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) |-> res_rejected_i == !exp_found)
      else begin
         $error("ERROR %0t alloc_rejected_o expected %0b got %0b",
                $time, !exp_found, $sampled(res_rejected_i));
         err_cnt++;
      end

   a_cu_id: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) && exp_found |-> res_cu_id_i == exp_cu)
      else begin
         $error("ERROR %0t alloc_cu_id_o expected %0d got %0d",
                $time, exp_cu, $sampled(res_cu_id_i));
         err_cnt++;
      end

   a_vgpr_start: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) && exp_found |-> res_vgpr_start_i == vgpr_start_sh[exp_cu])
      else begin
         $error("ERROR %0t alloc_vgpr_start_o expected %0d got %0d",
                $time, vgpr_start_sh[exp_cu], $sampled(res_vgpr_start_i));
         err_cnt++;
      end

   a_lds_start: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) && exp_found |-> res_lds_start_i == lds_start_sh[exp_cu])
      else begin
         $error("ERROR %0t alloc_lds_start_o expected %0d got %0d",
                $time, lds_start_sh[exp_cu], $sampled(res_lds_start_i));
         err_cnt++;
      end

   a_wg_id: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) && exp_found |-> res_wg_id_i == exp_wg_id)
      else begin
         $error("ERROR %0t alloc_wg_id_o expected %0d got %0d",
                $time, exp_wg_id, $sampled(res_wg_id_i));
         err_cnt++;
      end

   a_wf_count: assert property (@(posedge clk) disable iff (rst)
      $rose(res_valid_i) && exp_found |-> res_wf_count_i == exp_wf_cnt)
      else begin
         $error("ERROR %0t alloc_wf_count_o expected %0d got %0d",
                $time, exp_wf_cnt, $sampled(res_wf_count_i));
         err_cnt++;
      end

   // Held result may reload only in the cycle right after an ack
   a_hold: assert property (@(posedge clk) disable iff (rst)
      res_valid_i && !alloc_ack_i && !$past(alloc_ack_i) |=>
         res_valid_i && $stable({res_rejected_i, res_wg_id_i, res_cu_id_i,
                                 res_wf_count_i, res_vgpr_start_i, res_lds_start_i}))
      else begin
         $error("Result outputs changed while the result was held without an ack");
         err_cnt++;
      end

endmodule

bind wg_alloc_top wg_alloc_checker u_checker (
   .clk(clk), .rst(rst), .start_alloc_i(start_alloc_i), .req_wg_id_i(req_wg_id_i),
   .req_vgpr_size_i(req_vgpr_size_i), .req_lds_size_i(req_lds_size_i),
   .req_num_wf_i(req_num_wf_i), .cu_busy_i(cu_busy_i), .alloc_ack_i(alloc_ack_i),
   .upd_valid_i(upd_valid_i), .upd_cu_id_i(upd_cu_id_i),
   .upd_vgpr_start_i(upd_vgpr_start_i), .upd_vgpr_free_i(upd_vgpr_free_i),
   .upd_lds_start_i(upd_lds_start_i), .upd_lds_free_i(upd_lds_free_i),
   .upd_wf_free_i(upd_wf_free_i),
   .res_valid_i(alloc_valid_o), .res_rejected_i(alloc_rejected_o),
   .res_wg_id_i(alloc_wg_id_o), .res_cu_id_i(alloc_cu_id_o),
   .res_wf_count_i(alloc_wf_count_o), .res_vgpr_start_i(alloc_vgpr_start_o),
   .res_lds_start_i(alloc_lds_start_o)
);

/* verification/wg_alloc_tb.sv */
`include "wg_alloc_params.svh"

module wg_alloc_tb import wg_alloc_pkg::*; ();

   // Up to 40 requests of at most 20 cycles each, plus table writes
   localparam int TIMEOUT_CYC  = 40 * 20 + 200;
   localparam int NUM_RAND_REQ = 36;

   logic       clk;
   logic       rst;
   logic       start_alloc;
   wg_id_t     req_wg_id;
   vgpr_size_t req_vgpr_size;
   lds_size_t  req_lds_size;
   wf_cnt_t    req_num_wf;
   cu_mask_t   cu_busy;
   logic       alloc_ack;
   logic       upd_valid;
   cu_id_t     upd_cu_id;
   vgpr_addr_t upd_vgpr_start;
   vgpr_size_t upd_vgpr_free;
   lds_addr_t  upd_lds_start;
   lds_size_t  upd_lds_free;
   wf_slots_t  upd_wf_free;
   logic       alloc_valid;
   logic       alloc_rejected;
   wg_id_t     alloc_wg_id;
   cu_id_t     alloc_cu_id;
   wf_cnt_t    alloc_wf_count;
   vgpr_addr_t alloc_vgpr_start;
   lds_addr_t  alloc_lds_start;

   int         seed;
   int         cycle_cnt;
   int         errs;

   wg_alloc_top u_wg_alloc_top (
      .clk(clk), .rst(rst), .start_alloc_i(start_alloc), .req_wg_id_i(req_wg_id),
      .req_vgpr_size_i(req_vgpr_size), .req_lds_size_i(req_lds_size),
      .req_num_wf_i(req_num_wf), .cu_busy_i(cu_busy), .alloc_ack_i(alloc_ack),
      .upd_valid_i(upd_valid), .upd_cu_id_i(upd_cu_id),
      .upd_vgpr_start_i(upd_vgpr_start), .upd_vgpr_free_i(upd_vgpr_free),
      .upd_lds_start_i(upd_lds_start), .upd_lds_free_i(upd_lds_free),
      .upd_wf_free_i(upd_wf_free),
      .alloc_valid_o(alloc_valid), .alloc_rejected_o(alloc_rejected),
      .alloc_wg_id_o(alloc_wg_id), .alloc_cu_id_o(alloc_cu_id),
      .alloc_wf_count_o(alloc_wf_count), .alloc_vgpr_start_o(alloc_vgpr_start),
      .alloc_lds_start_o(alloc_lds_start)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   //////////////////////////////
   // Stimulus tasks
   //////////////////////////////

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic write_entry(input cu_id_t cu, input vgpr_addr_t v_start,
                              input vgpr_size_t v_free, input lds_addr_t l_start,
                              input lds_size_t l_free, input wf_slots_t w_free);
      upd_valid      = 1'b1;
      upd_cu_id      = cu;
      upd_vgpr_start = v_start;
      upd_vgpr_free  = v_free;
      upd_lds_start  = l_start;
      upd_lds_free   = l_free;
      upd_wf_free    = w_free;
      next_cycle();
      upd_valid      = 1'b0;
   endtask

   task automatic random_entry(input cu_id_t cu);
      vgpr_addr_t v_start;
      vgpr_size_t v_free;
      lds_addr_t  l_start;
      lds_size_t  l_free;
      wf_slots_t  w_free;
      v_start = vgpr_addr_t'($random(seed));
      v_free  = vgpr_size_t'($unsigned($random(seed)) % 65);
      l_start = lds_addr_t'($random(seed));
      l_free  = lds_size_t'($unsigned($random(seed)) % 65);
      w_free  = wf_slots_t'($unsigned($random(seed)) % 17);
      write_entry(cu, v_start, v_free, l_start, l_free, w_free);
   endtask

   // One request, held for a few cycles before the ack
   task automatic send_request(input wg_id_t wg, input vgpr_size_t v_need,
                               input lds_size_t l_need, input wf_cnt_t w_need,
                               input cu_mask_t busy, input int hold);
      start_alloc   = 1'b1;
      req_wg_id     = wg;
      req_vgpr_size = v_need;
      req_lds_size  = l_need;
      req_num_wf    = w_need;
      cu_busy       = busy;
      next_cycle();
      start_alloc   = 1'b0;
      while (!alloc_valid) begin
         next_cycle();
      end
      repeat (hold) next_cycle();
      alloc_ack = 1'b1;
      next_cycle();
      alloc_ack = 1'b0;
      repeat (4) next_cycle();
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      vgpr_size_t v_need;
      lds_size_t  l_need;
      wf_cnt_t    w_need;
      cu_mask_t   busy;
      seed           = 32'h4451_ad18;
      rst            = 1'b1;
      start_alloc    = 1'b0;
      req_wg_id      = '0;
      req_vgpr_size  = '0;
      req_lds_size   = '0;
      req_num_wf     = '0;
      cu_busy        = '0;
      alloc_ack      = 1'b0;
      upd_valid      = 1'b0;
      upd_cu_id      = '0;
      upd_vgpr_start = '0;
      upd_vgpr_free  = '0;
      upd_lds_start  = '0;
      upd_lds_free   = '0;
      upd_wf_free    = '0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;
      repeat (5) next_cycle();

      for (int cu = 0; cu < `WA_NUM_CU; cu++) begin
         random_entry(cu_id_t'(cu));
      end
      repeat (2) next_cycle();

      for (int n = 0; n < NUM_RAND_REQ; n++) begin
         // Rewrite one entry now and then, never with a request in flight
         if (n % 9 == 8) begin
            random_entry(cu_id_t'($random(seed)));
            repeat (2) next_cycle();
         end
         v_need = vgpr_size_t'($unsigned($random(seed)) % 49);
         l_need = lds_size_t'($unsigned($random(seed)) % 49);
         w_need = wf_cnt_t'($random(seed));
         busy   = cu_mask_t'($random(seed) & $random(seed));
         send_request(wg_id_t'(n), v_need, l_need, w_need, busy, n % 4);
      end

      // Only CU 5 has room
      for (int cu = 0; cu < `WA_NUM_CU; cu++) begin
         write_entry(cu_id_t'(cu), vgpr_addr_t'(cu * 7), (cu == 5) ? 7'd64 : 7'd0,
                     lds_addr_t'(cu * 5), (cu == 5) ? 7'd64 : 7'd0,
                     (cu == 5) ? 5'd16 : 5'd0);
      end
      repeat (2) next_cycle();
      send_request(6'd40, 7'd20, 7'd20, 3'd4, 8'h20, 1);
      send_request(6'd41, 7'd20, 7'd20, 3'd4, 8'h00, 1);

      repeat (4) next_cycle();
      errs = u_wg_alloc_top.u_checker.err_cnt;
      $display("Checks finished with %0d errors", errs);
      if (errs == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Test failed");
      $finish;
   end

endmodule

/* wg_alloc.f */
+incdir+design
design/wg_alloc_pkg.sv
design/wg_alloc_ifs.sv
design/alloc_cam.sv
design/start_ram.sv
design/cu_select.sv
design/alloc_pipe_ctrl.sv
design/wg_alloc_top.sv
verification/wg_alloc_checker.sv
verification/wg_alloc_tb.sv
